/* rtl/rv_pkg.sv */
`default_nettype none

package rv_pkg;

  // Datapath and register file widths
  localparam int XLEN   = 32;
  localparam int REG_AW = 4;

  // Multicycle controller states
  typedef enum logic [2:0] {
    S_FETCH  = 3'd0,
    S_DECODE = 3'd1,
    S_EXEC   = 3'd2,
    S_MEM    = 3'd3,
    S_WB     = 3'd4,
    S_HALT   = 3'd5,
    S_FAULT  = 3'd6
  } core_state_t;

  // Major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_LUI    = 7'b0110111,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_BRANCH = 7'b1100011,
    OP_JAL    = 7'b1101111,
    OP_SYSTEM = 7'b1110011
  } opcode_t;

  typedef enum logic [1:0] {
    ALU_ADD    = 2'd0,
    ALU_SUB    = 2'd1,
    ALU_PASS_B = 2'd2
  } alu_op_t;

  // Full EBREAK encoding above the opcode field
  localparam logic [24:0] EBREAK_HI = 25'h0002000;

endpackage

`default_nettype wire

/* rtl/core_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module core_ctrl (
  input  wire                  clk,
  input  wire                  rst,
  input  wire                  mem_ack_i,
  input  wire                  timeout_i,
  input  wire rv_pkg::opcode_t opcode_i,
  input  wire                  is_load_i,
  input  wire                  is_store_i,
  input  wire                  illegal_i,
  output logic                 mem_req_o,
  output logic                 mem_we_o,
  output logic                 mem_phase_data_o,
  output logic                 ir_load_o,
  output logic                 pc_load_o,
  output logic                 rf_we_o,
  output logic                 halt_o,
  output logic                 fault_o,
  output rv_pkg::core_state_t  state_o
);

  rv_pkg::core_state_t state_q;
  rv_pkg::core_state_t state_d;
  logic                req_q;
  logic                we_q;
  logic                ack_valid;
  logic                writes_rd;

  // Only an acknowledge to our own request counts
  assign ack_valid = mem_ack_i & req_q;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      rv_pkg::S_FETCH:
        if (ack_valid)
          state_d = rv_pkg::S_DECODE;
        else if (timeout_i)
          state_d = rv_pkg::S_FAULT;
      rv_pkg::S_DECODE:
        if (illegal_i)
          state_d = rv_pkg::S_FAULT;
        else if (opcode_i == rv_pkg::OP_SYSTEM)
          state_d = rv_pkg::S_HALT;
        else
          state_d = rv_pkg::S_EXEC;
      rv_pkg::S_EXEC:
        state_d = (is_load_i || is_store_i) ? rv_pkg::S_MEM : rv_pkg::S_WB;
      rv_pkg::S_MEM:
        if (ack_valid)
          state_d = rv_pkg::S_WB;
        else if (timeout_i)
          state_d = rv_pkg::S_FAULT;
      rv_pkg::S_WB:
        state_d = rv_pkg::S_FETCH;
      default:
        state_d = state_q;
    endcase
  end

  // Request level follows the next state, so it drops right after the acknowledge
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q <= rv_pkg::S_FETCH;
      req_q   <= 1'b0;
      we_q    <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      req_q   <= (state_d == rv_pkg::S_FETCH) || (state_d == rv_pkg::S_MEM);
      we_q    <= (state_d == rv_pkg::S_MEM) && is_store_i;
    end
  end

  assign writes_rd = (opcode_i == rv_pkg::OP_IMM) || (opcode_i == rv_pkg::OP_REG) ||
                     (opcode_i == rv_pkg::OP_LUI) || (opcode_i == rv_pkg::OP_JAL) ||
                     (opcode_i == rv_pkg::OP_LOAD);

  assign mem_req_o        = req_q;
  assign mem_we_o         = we_q;
  assign mem_phase_data_o = (state_q == rv_pkg::S_MEM);
  assign ir_load_o        = (state_q == rv_pkg::S_FETCH) && ack_valid;
  assign pc_load_o        = (state_q == rv_pkg::S_WB);
  assign rf_we_o          = (state_q == rv_pkg::S_WB) && writes_rd;
  assign halt_o           = (state_q == rv_pkg::S_HALT);
  assign fault_o          = (state_q == rv_pkg::S_FAULT);
  assign state_o          = state_q;

endmodule

`default_nettype wire

/* rtl/mem_wait_timer.sv */
`timescale 1ns/1ns
`default_nettype none

module mem_wait_timer #(
  parameter int MEM_TIMEOUT = 16
) (
  input  wire  clk,
  input  wire  rst,
  input  wire  req_i,
  input  wire  ack_i,
  output logic timeout_o
);

  localparam int CNT_W = $clog2(MEM_TIMEOUT + 1);
  localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(MEM_TIMEOUT);

  logic [CNT_W-1:0] wait_cnt_q;

  // Counts cycles of an unanswered request, saturates at the limit
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wait_cnt_q <= '0;
    end
    else if (!req_i || ack_i)
    begin
      wait_cnt_q <= '0;
    end
    else if (wait_cnt_q != CNT_MAX)
    begin
      wait_cnt_q <= wait_cnt_q + 1'b1;
    end
  end

  assign timeout_o = (wait_cnt_q == CNT_MAX);

endmodule

`default_nettype wire

/* rtl/fetch_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module fetch_unit #(
  parameter logic [rv_pkg::XLEN-1:0] RESET_PC = '0
) (
  input  wire                     clk,
  input  wire                     rst,
  input  wire                     ir_load_i,
  input  wire                     pc_load_i,
  input  wire [rv_pkg::XLEN-1:0]  mem_rdata_i,
  input  wire [rv_pkg::XLEN-1:0]  next_pc_i,
  output logic [rv_pkg::XLEN-1:0] pc_o,
  output logic [31:0]             instr_o
);

  logic [rv_pkg::XLEN-1:0] pc_q;
  logic [31:0]             ir_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc_q <= RESET_PC;
    end
    else if (pc_load_i)
    begin
      pc_q <= next_pc_i;
    end
  end

  // Instruction word, captured on the fetch acknowledge
  always_ff @(posedge clk)
  begin
    if (ir_load_i)
    begin
      ir_q <= mem_rdata_i[31:0];
    end
  end

  assign pc_o    = pc_q;
  assign instr_o = ir_q;

endmodule

`default_nettype wire

/* rtl/reg_file.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_file (
  input  wire                       clk,
  input  wire                       rst,
  input  wire                       we_i,
  input  wire [rv_pkg::REG_AW-1:0]  waddr_i,
  input  wire [rv_pkg::XLEN-1:0]    wdata_i,
  input  wire [rv_pkg::REG_AW-1:0]  raddr1_i,
  input  wire [rv_pkg::REG_AW-1:0]  raddr2_i,
  output logic [rv_pkg::XLEN-1:0]   rdata1_o,
  output logic [rv_pkg::XLEN-1:0]   rdata2_o
);

  localparam int NREGS = 1 << rv_pkg::REG_AW;

  logic [rv_pkg::XLEN-1:0] regs_q [NREGS];

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < NREGS; i++)
        regs_q[i] <= '0;
    end
    else if (we_i && (waddr_i != '0))
    begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // x0 never written, so it keeps its reset value of zero
  assign rdata1_o = regs_q[raddr1_i];
  assign rdata2_o = regs_q[raddr2_i];

endmodule

`default_nettype wire

/* rtl/decode_exec.sv */
`timescale 1ns/1ns
`default_nettype none

module decode_exec (
  input  wire                      clk,
  input  wire                      rst,
  input  wire [31:0]               instr_i,
  input  wire [rv_pkg::XLEN-1:0]   pc_i,
  input  wire [rv_pkg::XLEN-1:0]   rs1_data_i,
  input  wire [rv_pkg::XLEN-1:0]   rs2_data_i,
  input  wire [rv_pkg::XLEN-1:0]   mem_rdata_i,
  input  wire                      mem_ack_i,
  output logic [rv_pkg::REG_AW-1:0] rs1_o,
  output logic [rv_pkg::REG_AW-1:0] rs2_o,
  output logic [rv_pkg::REG_AW-1:0] rd_o,
  output rv_pkg::opcode_t          opcode_o,
  output logic                     is_load_o,
  output logic                     is_store_o,
  output logic                     illegal_o,
  output logic [rv_pkg::XLEN-1:0]  mem_addr_o,
  output logic [rv_pkg::XLEN-1:0]  mem_wdata_o,
  output logic [rv_pkg::XLEN-1:0]  wb_data_o,
  output logic [rv_pkg::XLEN-1:0]  next_pc_o
);

  rv_pkg::opcode_t         opcode;
  rv_pkg::alu_op_t         alu_op;
  logic [2:0]              funct3;
  logic [6:0]              funct7;
  logic [31:0]             imm_i;
  logic [31:0]             imm_s;
  logic [31:0]             imm_b;
  logic [31:0]             imm_u;
  logic [31:0]             imm_j;
  logic [rv_pkg::XLEN-1:0] op_b;
  logic [rv_pkg::XLEN-1:0] alu_result;
  logic [rv_pkg::XLEN-1:0] pc_plus4;
  logic [rv_pkg::XLEN-1:0] next_pc_d;
  logic                    is_load;
  logic                    is_store;
  logic                    illegal;
  logic                    br_taken;
  logic [rv_pkg::XLEN-1:0] result_q;
  logic [rv_pkg::XLEN-1:0] next_pc_q;
  logic [rv_pkg::XLEN-1:0] load_q;

  assign opcode = rv_pkg::opcode_t'(instr_i[6:0]);
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // RV32E register fields, low four bits only
  assign rd_o  = instr_i[7 +: rv_pkg::REG_AW];
  assign rs1_o = instr_i[15 +: rv_pkg::REG_AW];
  assign rs2_o = instr_i[20 +: rv_pkg::REG_AW];

  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                  instr_i[11:8], 1'b0};
  assign imm_u = {instr_i[31:12], 12'b0};
  assign imm_j = {{11{instr_i[31]}}, instr_i[31], instr_i[19:12], instr_i[20],
                  instr_i[30:21], 1'b0};

  always_comb
  begin
    alu_op   = rv_pkg::ALU_ADD;
    op_b     = rs2_data_i;
    is_load  = 1'b0;
    is_store = 1'b0;
    illegal  = 1'b0;
    case (opcode)
      rv_pkg::OP_IMM:
      begin
        op_b    = imm_i;
        illegal = (funct3 != 3'b000);
      end
      rv_pkg::OP_REG:
      begin
        if (funct7 == 7'b0100000)
          alu_op = rv_pkg::ALU_SUB;
        illegal = (funct3 != 3'b000) || ((funct7 != 7'b0) && (funct7 != 7'b0100000));
      end
      rv_pkg::OP_LUI:
      begin
        alu_op = rv_pkg::ALU_PASS_B;
        op_b   = imm_u;
      end
      rv_pkg::OP_LOAD:
      begin
        op_b    = imm_i;
        is_load = 1'b1;
        illegal = (funct3 != 3'b010);
      end
      rv_pkg::OP_STORE:
      begin
        op_b     = imm_s;
        is_store = 1'b1;
        illegal  = (funct3 != 3'b010);
      end
      // BEQ and BNE only
      rv_pkg::OP_BRANCH: illegal = (funct3[2:1] != 2'b00);
      rv_pkg::OP_JAL:    illegal = 1'b0;
      rv_pkg::OP_SYSTEM: illegal = (instr_i[31:7] != rv_pkg::EBREAK_HI);
      default:           illegal = 1'b1;
    endcase
  end

  always_comb
  begin
    case (alu_op)
      rv_pkg::ALU_SUB:    alu_result = rs1_data_i - op_b;
      rv_pkg::ALU_PASS_B: alu_result = op_b;
      default:            alu_result = rs1_data_i + op_b;
    endcase
  end

  assign pc_plus4 = pc_i + 32'd4;
  assign br_taken = (opcode == rv_pkg::OP_BRANCH) && ((rs1_data_i == rs2_data_i) ^ funct3[0]);

  always_comb
  begin
    if (opcode == rv_pkg::OP_JAL)
      next_pc_d = pc_i + imm_j;
    else if (br_taken)
      next_pc_d = pc_i + imm_b;
    else
      next_pc_d = pc_plus4;
  end

  // Operands hold still from decode through writeback, so the value taken at
  // the end of execute stays put until the PC moves
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      result_q  <= '0;
      next_pc_q <= '0;
      load_q    <= '0;
    end
    else
    begin
      result_q  <= alu_result;
      next_pc_q <= next_pc_d;
      // Last acknowledged word; for a load that is the data phase
      if (mem_ack_i)
        load_q <= mem_rdata_i;
    end
  end

  assign opcode_o    = opcode;
  assign is_load_o   = is_load;
  assign is_store_o  = is_store;
  assign illegal_o   = illegal;
  assign mem_addr_o  = result_q;
  assign mem_wdata_o = rs2_data_i;
  assign next_pc_o   = next_pc_q;
  assign wb_data_o   = (opcode == rv_pkg::OP_JAL) ? pc_plus4 :
                       is_load                    ? load_q   : result_q;

endmodule

`default_nettype wire

/* rtl/rv_core.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_core #(
  parameter logic [rv_pkg::XLEN-1:0] RESET_PC    = '0,
  parameter int                      MEM_TIMEOUT = 16
) (
  input  wire                     clk,
  input  wire                     rst,
  output logic                    mem_req_o,
  output logic                    mem_we_o,
  output logic [rv_pkg::XLEN-1:0] mem_addr_o,
  output logic [rv_pkg::XLEN-1:0] mem_wdata_o,
  input  wire [rv_pkg::XLEN-1:0]  mem_rdata_i,
  input  wire                     mem_ack_i,
  output logic                    halt_o,
  output logic                    fault_o
);

  logic                      mem_req;
  logic                      timeout;
  logic                      mem_phase_data;
  logic                      ir_load;
  logic                      pc_load;
  logic                      rf_we;
  logic                      is_load;
  logic                      is_store;
  logic                      illegal;
  rv_pkg::opcode_t           opcode;
  logic [rv_pkg::XLEN-1:0]   pc;
  logic [31:0]               instr;
  logic [rv_pkg::XLEN-1:0]   next_pc;
  logic [rv_pkg::REG_AW-1:0] rs1;
  logic [rv_pkg::REG_AW-1:0] rs2;
  logic [rv_pkg::REG_AW-1:0] rd;
  logic [rv_pkg::XLEN-1:0]   rs1_data;
  logic [rv_pkg::XLEN-1:0]   rs2_data;
  logic [rv_pkg::XLEN-1:0]   wb_data;
  logic [rv_pkg::XLEN-1:0]   data_addr;

  core_ctrl i_core_ctrl (
    .clk(clk), .rst(rst),
    .mem_ack_i(mem_ack_i), .timeout_i(timeout),
    .opcode_i(opcode), .is_load_i(is_load), .is_store_i(is_store), .illegal_i(illegal),
    .mem_req_o(mem_req), .mem_we_o(mem_we_o), .mem_phase_data_o(mem_phase_data),
    .ir_load_o(ir_load), .pc_load_o(pc_load), .rf_we_o(rf_we),
    .halt_o(halt_o), .fault_o(fault_o), .state_o()
  );

  mem_wait_timer #(.MEM_TIMEOUT(MEM_TIMEOUT)) i_mem_wait_timer (
    .clk(clk), .rst(rst),
    .req_i(mem_req), .ack_i(mem_ack_i),
    .timeout_o(timeout)
  );

  fetch_unit #(.RESET_PC(RESET_PC)) i_fetch_unit (
    .clk(clk), .rst(rst),
    .ir_load_i(ir_load), .pc_load_i(pc_load),
    .mem_rdata_i(mem_rdata_i), .next_pc_i(next_pc),
    .pc_o(pc), .instr_o(instr)
  );

  reg_file i_reg_file (
    .clk(clk), .rst(rst),
    .we_i(rf_we), .waddr_i(rd), .wdata_i(wb_data),
    .raddr1_i(rs1), .raddr2_i(rs2),
    .rdata1_o(rs1_data), .rdata2_o(rs2_data)
  );

  decode_exec i_decode_exec (
    .clk(clk), .rst(rst),
    .instr_i(instr), .pc_i(pc),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
    .mem_rdata_i(mem_rdata_i), .mem_ack_i(mem_ack_i),
    .rs1_o(rs1), .rs2_o(rs2), .rd_o(rd),
    .opcode_o(opcode), .is_load_o(is_load), .is_store_o(is_store), .illegal_o(illegal),
    .mem_addr_o(data_addr), .mem_wdata_o(mem_wdata_o),
    .wb_data_o(wb_data), .next_pc_o(next_pc)
  );

  // Shared port, PC during fetch and the data address during S_MEM
  assign mem_addr_o = mem_phase_data ? data_addr : pc;
  assign mem_req_o  = mem_req;

endmodule

`default_nettype wire

/* sim/rv_core_sva.sv */
`timescale 1ns/1ns
`default_nettype none

module rv_core_sva (
  input wire                      clk,
  input wire                      rst,
  input wire                      req_i,
  input wire                      we_i,
  input wire                      ack_i,
  input wire                      timeout_i,
  input wire                      phase_data_i,
  input wire                      halt_i,
  input wire                      fault_i,
  input wire rv_pkg::core_state_t state_i
);

  // Address source and direction hold while the request waits
  assert property (@(posedge clk) disable iff (rst)
    req_i && !ack_i && !timeout_i |=> req_i && $stable(phase_data_i) && $stable(we_i))
  else $error("request changed before its acknowledge");

  assert property (@(posedge clk) disable iff (rst) req_i && ack_i |=> !req_i)
  else $error("request still high after acknowledge");

  assert property (@(posedge clk) disable iff (rst)
    (state_i == rv_pkg::S_HALT || state_i == rv_pkg::S_FAULT) |-> !req_i)
  else $error("request issued while halted or faulted");

  // Halt and fault are terminal until reset, and never seen together
  assert property (@(posedge clk) disable iff (rst) halt_i |=> halt_i && !fault_i)
  else $error("halt left or fault raised before reset");

  assert property (@(posedge clk) disable iff (rst) fault_i |=> fault_i && !halt_i)
  else $error("fault left or halt raised before reset");

endmodule

bind core_ctrl rv_core_sva i_rv_core_sva (
  .clk(clk), .rst(rst),
  .req_i(mem_req_o), .we_i(mem_we_o), .ack_i(mem_ack_i), .timeout_i(timeout_i),
  .phase_data_i(mem_phase_data_o), .halt_i(halt_o), .fault_i(fault_o),
  .state_i(state_o)
);

`default_nettype wire

/* sim/tb_rv_core.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_rv_core;

  localparam int          MEM_TIMEOUT = 16;
  localparam int          RUN_LIMIT   = 4000;
  localparam logic [31:0] EBREAK      = 32'h0010_0073;

  logic        clk;
  logic        rst;
  logic        mem_req;
  logic        mem_we;
  logic [31:0] mem_addr;
  logic [31:0] mem_wdata;
  logic [31:0] mem_rdata;
  logic        mem_ack;
  logic        halt;
  logic        fault;

  logic [31:0] mem [0:1023];
  int          wp;
  int          wait_cnt;
  int          lat;
  int          lat_fixed;
  bit          lat_random;
  bit          ack_off;
  int          seed;
  int          errors;
  int          checks;

  rv_core #(.RESET_PC(32'h0), .MEM_TIMEOUT(MEM_TIMEOUT)) i_rv_core (
    .clk(clk), .rst(rst),
    .mem_req_o(mem_req), .mem_we_o(mem_we), .mem_addr_o(mem_addr),
    .mem_wdata_o(mem_wdata), .mem_rdata_i(mem_rdata), .mem_ack_i(mem_ack),
    .halt_o(halt), .fault_o(fault)
  );

  always #4 clk = ~clk;

  // Instruction encoders, RV32 base formats
  function automatic logic [31:0] addi(input int rd, input int rs1, input int imm);
    return {12'(imm), 5'(rs1), 3'b000, 5'(rd), 7'b0010011};
  endfunction

  function automatic logic [31:0] add_regs(input int rd, input int rs1, input int rs2);
    return {7'b0000000, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), 7'b0110011};
  endfunction

  function automatic logic [31:0] sub_regs(input int rd, input int rs1, input int rs2);
    return {7'b0100000, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), 7'b0110011};
  endfunction

  function automatic logic [31:0] lui(input int rd, input int imm20);
    return {20'(imm20), 5'(rd), 7'b0110111};
  endfunction

  function automatic logic [31:0] lw(input int rd, input int rs1, input int off);
    return {12'(off), 5'(rs1), 3'b010, 5'(rd), 7'b0000011};
  endfunction

  function automatic logic [31:0] sw(input int rs2, input int rs1, input int off);
    logic [11:0] s;
    s = 12'(off);
    return {s[11:5], 5'(rs2), 5'(rs1), 3'b010, s[4:0], 7'b0100011};
  endfunction

  // f3 000 is BEQ, 001 is BNE
  function automatic logic [31:0] branch(input int rs1, input int rs2, input int off,
                                         input logic [2:0] f3);
    logic [12:0] b;
    b = 13'(off);
    return {b[12], b[10:5], 5'(rs2), 5'(rs1), f3, b[4:1], b[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jal(input int rd, input int off);
    logic [20:0] j;
    j = 21'(off);
    return {j[20], j[10:1], j[11], j[19:12], 5'(rd), 7'b1101111};
  endfunction

  function automatic logic [31:0] sext12(input int imm);
    logic [11:0] v;
    v = 12'(imm);
    return {{20{v[11]}}, v};
  endfunction

  function automatic int next_latency();
    if (lat_random)
      return $random(seed) & 3;
    return lat_fixed;
  endfunction

  // Memory model, one ack pulse per request after the chosen latency
  always @(negedge clk)
  begin
    mem_ack = 1'b0;
    if (!mem_req || ack_off)
      wait_cnt = 0;
    else if (wait_cnt < lat)
      wait_cnt++;
    else
    begin
      mem_ack   = 1'b1;
      mem_rdata = mem[mem_addr[11:2]];
      if (mem_we)
        mem[mem_addr[11:2]] = mem_wdata;
      wait_cnt = 0;
      lat      = next_latency();
    end
  end

  task automatic clear_memory();
    for (int i = 0; i < 1024; i++)
      mem[i] = 32'hA5A5_0000 | 32'(i);
    wp = 0;
  endtask

  task automatic emit(input logic [31:0] insn);
    mem[wp] = insn;
    wp++;
  endtask

  task automatic set_latency(input int cycles, input bit random);
    lat_fixed  = cycles;
    lat_random = random;
    lat        = next_latency();
  endtask

  task automatic reset_core();
    @(negedge clk);
    rst = 1'b1;
    repeat (5) @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    if (act !== exp)
    begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_word(input string name, input int addr, input logic [31:0] exp);
    check_value(name, exp, mem[addr / 4]);
  endtask

  task automatic run_program(input string name);
    int cycles;
    reset_core();
    cycles = 0;
    while (!halt && !fault && cycles < RUN_LIMIT)
    begin
      @(negedge clk);
      cycles++;
    end
    if (!halt && !fault)
    begin
      $display("%s: core neither halted nor faulted within %0d cycles", name, RUN_LIMIT);
      errors++;
    end
  endtask

  task automatic test_arith();
    logic [31:0] r1;
    logic [31:0] r2;
    logic [31:0] r5;
    clear_memory();
    set_latency(2, 1'b0);
    emit(addi(1, 0, -5));
    emit(addi(2, 0, 2047));
    emit(add_regs(3, 1, 2));
    emit(sub_regs(4, 1, 2));
    emit(lui(5, 'hFFFFF));
    emit(addi(6, 5, -1));
    emit(sw(3, 0, 'h400));
    emit(sw(4, 0, 'h404));
    emit(sw(5, 0, 'h408));
    emit(sw(6, 0, 'h40C));
    emit(EBREAK);
    run_program("arith");
    r1 = sext12(-5);
    r2 = sext12(2047);
    r5 = {20'hFFFFF, 12'h000};
    check_word("arith_add", 'h400, r1 + r2);
    check_word("arith_sub", 'h404, r1 - r2);
    check_word("arith_lui", 'h408, r5);
    check_word("arith_addi_neg", 'h40C, r5 + sext12(-1));
  endtask

  task automatic test_load_store();
    clear_memory();
    set_latency(0, 1'b1);
    emit(lui(1, 'h12345));
    emit(addi(1, 1, 'h678));
    emit(sw(1, 0, 'h400));
    emit(lw(2, 0, 'h400));
    emit(addi(3, 0, -100));
    emit(sw(3, 0, 'h404));
    emit(lw(4, 0, 'h404));
    emit(sw(2, 0, 'h408));
    emit(sw(4, 0, 'h40C));
    emit(EBREAK);
    run_program("load_store");
    check_word("ldst_copy1", 'h408, {20'h12345, 12'h000} + sext12('h678));
    check_word("ldst_copy2", 'h40C, sext12(-100));
    set_latency(1, 1'b0);
  endtask

  task automatic test_branch();
    int jal_pc;
    clear_memory();
    set_latency(1, 1'b0);
    emit(addi(1, 0, 7));
    emit(addi(2, 0, 7));
    emit(addi(3, 0, 3));
    emit(branch(1, 2, 8, 3'b000));
    emit(addi(10, 0, 1));
    emit(branch(1, 2, 8, 3'b001));
    emit(addi(11, 0, 2));
    emit(branch(1, 3, 8, 3'b000));
    emit(addi(12, 0, 3));
    emit(branch(1, 3, 8, 3'b001));
    emit(addi(13, 0, 4));
    jal_pc = wp * 4;
    emit(jal(14, 8));
    emit(addi(15, 0, 5));
    for (int r = 10; r <= 15; r++)
      emit(sw(r, 0, 'h400 + 4 * (r - 10)));
    emit(EBREAK);
    run_program("branch");
    // Taken paths skip their marker, fall-through paths set it
    check_word("beq_taken", 'h400, 32'd0);
    check_word("bne_not_taken", 'h404, 32'd2);
    check_word("beq_not_taken", 'h408, 32'd3);
    check_word("bne_taken", 'h40C, 32'd0);
    check_word("jal_link", 'h410, 32'(jal_pc + 4));
    check_word("jal_skip", 'h414, 32'd0);
  endtask

  task automatic test_x0();
    clear_memory();
    set_latency(1, 1'b0);
    emit(addi(1, 0, 9));
    emit(addi(0, 0, 5));
    emit(add_regs(0, 1, 1));
    emit(lui(0, 'hABCDE));
    emit(lw(0, 0, 'h400));
    emit(sw(0, 0, 'h430));
    emit(EBREAK);
    run_program("x0");
    check_word("x0_zero", 'h430, 32'd0);
  endtask

  task automatic test_ebreak();
    int req_seen;
    clear_memory();
    set_latency(1, 1'b0);
    emit(addi(1, 0, 1));
    emit(sw(1, 0, 'h440));
    emit(EBREAK);
    emit(sw(1, 0, 'h444));
    run_program("ebreak");
    req_seen = 0;
    repeat (20)
    begin
      @(negedge clk);
      if (mem_req)
        req_seen++;
    end
    check_value("ebreak_halt", 32'd1, {31'd0, halt});
    check_value("ebreak_fault", 32'd0, {31'd0, fault});
    check_value("ebreak_req_after_halt", 32'd0, 32'(req_seen));
    check_word("ebreak_store_before", 'h440, 32'd1);
    check_word("ebreak_store_after", 'h444, 32'hA5A5_0000 | 32'('h444 / 4));
  endtask

  task automatic test_faults();
    int cycles;
    clear_memory();
    set_latency(1, 1'b0);
    emit(addi(1, 0, 1));
    emit(32'hFFFF_FFFF);
    run_program("illegal");
    check_value("illegal_fault", 32'd1, {31'd0, fault});
    check_value("illegal_halt", 32'd0, {31'd0, halt});

    // Memory that never answers
    ack_off = 1'b1;
    reset_core();
    cycles = 0;
    while (!mem_req && cycles < 4)
    begin
      @(negedge clk);
      cycles++;
    end
    if (!mem_req)
    begin
      $display("timeout: no request after reset release");
      errors++;
    end
    cycles = 0;
    while (!fault && cycles < MEM_TIMEOUT + 2)
    begin
      @(negedge clk);
      cycles++;
    end
    if (!fault)
    begin
      $display("timeout: fault_o not raised within %0d cycles of the request",
               MEM_TIMEOUT + 2);
      errors++;
    end
    check_value("timeout_req_dropped", 32'd0, {31'd0, mem_req});
    ack_off = 1'b0;
  endtask

  initial
  begin
    clk        = 1'b0;
    rst        = 1'b1;
    mem_ack    = 1'b0;
    mem_rdata  = 32'd0;
    seed       = 42;
    errors     = 0;
    checks     = 0;
    ack_off    = 1'b0;
    wait_cnt   = 0;
    set_latency(0, 1'b0);
    test_arith();
    test_load_store();
    test_branch();
    test_x0();
    test_ebreak();
    test_faults();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* rv_core.f */
rtl/rv_pkg.sv
rtl/core_ctrl.sv
rtl/mem_wait_timer.sv
rtl/fetch_unit.sv
rtl/reg_file.sv
rtl/decode_exec.sv
rtl/rv_core.sv
sim/rv_core_sva.sv
sim/tb_rv_core.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_rv_core
FILELIST   := rv_core.f
BUILD_DIR  := obj_dir
LOG        := sim.log
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
PASS_MSG   := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
